// ==== compile.f ====
source/nf_settings_pkg.sv
source/nf_cpu_pkg.sv
source/nf_alu.sv
source/nf_i_exu.sv
source/nf_sign_ext.sv
source/nf_reg_file.sv
source/nf_control_unit.sv
source/nf_exec_top.sv
verif/nf_exec_tb.sv

// ==== Bender.yml ====
package:
  name: nf_exec

sources:
  - source/nf_settings_pkg.sv
  - source/nf_cpu_pkg.sv
  - source/nf_alu.sv
  - source/nf_i_exu.sv
  - source/nf_sign_ext.sv
  - source/nf_reg_file.sv
  - source/nf_control_unit.sv
  - source/nf_exec_top.sv
  - target: test
    files:
      - verif/nf_exec_tb.sv

// ==== verif/nf_exec_tb.sv ====
`timescale 1ns/1ps

module nf_exec_tb;

    localparam int          CLK_PERIOD      = 20;           // ns
    localparam int          DRIVE_DELAY     = 2;            // input skew after rising edge
    localparam int          CYCLES_PER_TEST = 10;           // 3 base + 3 stall + 4 margin
    localparam logic [31:0] LCG_SEED        = 32'h8a67c528;
    localparam logic [6:0]  OP_IMM          = 7'b0010011;   // i-type alu
    localparam logic [6:0]  OP_LOAD         = 7'b0000011;   // not handled by the stage

    logic           clk;
    logic           reset;
    logic           in_valid;
    logic   [31:0]  in_instr;
    logic           in_ready;
    logic           wb_valid;
    logic           wb_ready;
    logic   [4:0]   wb_rd;
    logic   [31:0]  wb_data;

    logic   [31:0]  lcg_state;              // back-pressure generator state
    logic           table_ready = 1'b0;     // releases the watchdog

    // stimulus table, one slot per test
    string          name_tab [$];
    logic   [31:0]  instr_tab [$];
    bit             wb_tab [$];             // write-back expected
    logic   [4:0]   rd_tab [$];
    logic   [31:0]  data_tab [$];

    nf_exec_top
    #(
        .REG_COUNT  ( 32        )
    )
    UUT
    (
        .clk        ( clk       ),
        .reset      ( reset     ),
        .in_valid   ( in_valid  ),
        .in_instr   ( in_instr  ),
        .in_ready   ( in_ready  ),
        .wb_valid   ( wb_valid  ),
        .wb_ready   ( wb_ready  ),
        .wb_rd      ( wb_rd     ),
        .wb_data    ( wb_data   )
    );

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;   // numerical recipes constants
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            abort_run("check failed");
        end
    endtask

    task automatic add_entry(input string name, input logic [31:0] instr, input bit exp_wb,
                             input logic [4:0] rd, input logic [31:0] data);
        name_tab.push_back(name);
        instr_tab.push_back(instr);
        wb_tab.push_back(exp_wb);
        rd_tab.push_back(rd);
        data_tab.push_back(data);
    endtask

    task automatic load_table();
        // register setup, signed immediates
        add_entry("addi x1",  i_type_word(12'h064, 0, 0, 1, OP_IMM), 1, 1, 32'h0000_0064);
        add_entry("addi x2",  i_type_word(12'hFF9, 0, 0, 2, OP_IMM), 1, 2, 32'hFFFF_FFF9);
        add_entry("addi x3",  i_type_word(12'h7FF, 0, 0, 3, OP_IMM), 1, 3, 32'h0000_07FF);
        add_entry("addi x4",  i_type_word(12'h800, 0, 0, 4, OP_IMM), 1, 4, 32'hFFFF_F800);
        add_entry("addi x5",  i_type_word(12'h000, 1, 0, 5, OP_IMM), 1, 5, 32'h0000_0064);
        // r-type, x2 negative
        add_entry("add x6",   r_type_word(7'h00, 2, 1, 0, 6), 1, 6, 32'h0000_005D);
        add_entry("sub x7",   r_type_word(7'h20, 2, 1, 0, 7), 1, 7, 32'h0000_006B);
        add_entry("sub x8",   r_type_word(7'h20, 1, 2, 0, 8), 1, 8, 32'hFFFF_FF95);
        add_entry("xor x9",   r_type_word(7'h00, 2, 1, 4, 9), 1, 9, 32'hFFFF_FF9D);
        add_entry("or x10",   r_type_word(7'h00, 3, 1, 6, 10), 1, 10, 32'h0000_07FF);
        add_entry("and x11",  r_type_word(7'h00, 2, 1, 7, 11), 1, 11, 32'h0000_0060);
        add_entry("slt x12",  r_type_word(7'h00, 1, 2, 2, 12), 1, 12, 32'h0000_0001);
        add_entry("sltu x13", r_type_word(7'h00, 1, 2, 3, 13), 1, 13, 32'h0000_0000);
        // remaining i-type alu ops
        add_entry("slti x14", i_type_word(12'hFFA, 2, 2, 14, OP_IMM), 1, 14, 32'h0000_0001);
        add_entry("sltiu x15", i_type_word(12'hFFF, 1, 3, 15, OP_IMM), 1, 15, 32'h0000_0001);
        add_entry("xori x16", i_type_word(12'hFFF, 1, 4, 16, OP_IMM), 1, 16, 32'hFFFF_FF9B);
        add_entry("ori x17",  i_type_word(12'h010, 1, 6, 17, OP_IMM), 1, 17, 32'h0000_0074);
        add_entry("andi x18", i_type_word(12'h00F, 2, 7, 18, OP_IMM), 1, 18, 32'h0000_0009);
        // shifts, x22 low 5 bits = 4 with upper bits set
        add_entry("slli x19", i_type_word(12'h004, 1, 1, 19, OP_IMM), 1, 19, 32'h0000_0640);
        add_entry("srli x20", i_type_word(12'h01C, 2, 5, 20, OP_IMM), 1, 20, 32'h0000_000F);
        add_entry("srai x21", i_type_word(12'h401, 2, 5, 21, OP_IMM), 1, 21, 32'hFFFF_FFFC);
        add_entry("addi x22", i_type_word(12'hFE4, 0, 0, 22, OP_IMM), 1, 22, 32'hFFFF_FFE4);
        add_entry("sll x23",  r_type_word(7'h00, 22, 1, 1, 23), 1, 23, 32'h0000_0640);
        add_entry("srl x24",  r_type_word(7'h00, 22, 2, 5, 24), 1, 24, 32'h0FFF_FFFF);
        add_entry("sra x25",  r_type_word(7'h20, 22, 4, 5, 25), 1, 25, 32'hFFFF_FF80);
        // lui and lui + addi
        add_entry("lui x26",  lui_word(20'h12345, 26), 1, 26, 32'h1234_5000);
        add_entry("addi x27", i_type_word(12'h678, 26, 0, 27, OP_IMM), 1, 27, 32'h1234_5678);
        add_entry("lui x28",  lui_word(20'hFFFFF, 28), 1, 28, 32'hFFFF_F000);
        // x0 target still shows on wb, reads back zero
        add_entry("addi x0",  i_type_word(12'h005, 1, 0, 0, OP_IMM), 1, 0, 32'h0000_0069);
        add_entry("add x29",  r_type_word(7'h00, 1, 0, 0, 29), 1, 29, 32'h0000_0064);
        // unsupported opcode dropped, next one accepted
        add_entry("lw x30",   i_type_word(12'h000, 1, 2, 30, OP_LOAD), 0, 0, 32'h0000_0000);
        add_entry("addi x30", i_type_word(12'h001, 0, 0, 30, OP_IMM), 1, 30, 32'h0000_0001);
        add_entry("sub x31",  r_type_word(7'h20, 26, 27, 0, 31), 1, 31, 32'h0000_0678);
    endtask

    // entered and left at DRIVE_DELAY after a rising edge
    task automatic run_entry(input int idx);
        int             stall;      // cycles of wb_ready low
        logic   [31:0]  held;       // wb_data seen at wb_valid rise
        in_valid = 1'b1;
        in_instr = instr_tab[idx];
        while (!in_ready)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        @(posedge clk);             // accepting edge
        #DRIVE_DELAY;
        in_valid = 1'b0;
        in_instr = '0;
        check_value({name_tab[idx], " in_ready busy"}, 32'd0, in_ready);
        @(posedge clk);             // exec edge
        #DRIVE_DELAY;
        if (!wb_tab[idx])
        begin
            if (wb_valid)
                abort_run($sformatf("unexpected write-back for %s", name_tab[idx]));
            check_value({name_tab[idx], " in_ready"}, 32'd1, in_ready);
            return;
        end
        if (!wb_valid)
            abort_run($sformatf("write-back missing for %s", name_tab[idx]));
        lcg_state = lcg_next(lcg_state);
        stall     = int'(lcg_state[17:16]);    // 0..3
        held      = wb_data;
        repeat (stall)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (!wb_valid)
                abort_run($sformatf("write-back dropped under back-pressure for %s",
                                    name_tab[idx]));
            check_value({name_tab[idx], " held data"}, held, wb_data);
        end
        wb_ready = 1'b1;
        check_value({name_tab[idx], " rd"}, 32'(rd_tab[idx]), 32'(wb_rd));
        check_value({name_tab[idx], " data"}, data_tab[idx], wb_data);
        @(posedge clk);             // transfer edge, reg file written
        #DRIVE_DELAY;
        wb_ready = 1'b0;
        check_value({name_tab[idx], " wb_valid after transfer"}, 32'd0, wb_valid);
        check_value({name_tab[idx], " in_ready after transfer"}, 32'd1, in_ready);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog sized from the table length
    initial
    begin
        wait (table_ready);
        #((name_tab.size() * CYCLES_PER_TEST + 4) * CLK_PERIOD);
        abort_run("timeout: design stopped responding");
    end

    initial
    begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_instr  = '0;
        wb_ready  = 1'b0;
        lcg_state = LCG_SEED;
        load_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);      // reset held for 2 cycles
        #DRIVE_DELAY;
        reset = 1'b0;
        check_value("reset in_ready", 32'd1, in_ready);
        check_value("reset wb_valid", 32'd0, wb_valid);
        for (int i = 0; i < name_tab.size(); i++)
            run_entry(i);
        $display("all tests passed");
        $finish;
    end

endmodule : nf_exec_tb

// ==== source/nf_exec_top.sv ====
`timescale 1ns/1ps

module nf_exec_top
#(
    parameter int REG_COUNT = 32                    // register file depth
)
(
    input   logic                           clk,        // clock
    input   logic                           reset,      // sync reset, active high
    input   logic                           in_valid,   // instruction offered
    input   nf_settings_pkg::instr_t        in_instr,   // instruction word
    output  logic                           in_ready,   // stage can accept
    output  logic                           wb_valid,   // write-back offered
    input   logic                           wb_ready,   // sink takes write-back
    output  nf_settings_pkg::reg_addr_t     wb_rd,      // destination index
    output  nf_settings_pkg::xlen_t         wb_data     // destination data
);

    import nf_settings_pkg::*;
    import nf_cpu_pkg::*;

    reg_addr_t      rs1;            // source indexes from decoder
    reg_addr_t      rs2;
    instr_t         instr_q;        // held instruction
    imm_sel_t       imm_sel;
    srca_sel_t      srca_sel;
    srcb_sel_t      srcb_sel;
    shift_sel_t     shift_sel;
    alu_code_t      alu_code;
    xlen_t          rd1;            // operand values
    xlen_t          rd2;
    xlen_t          ext_data;       // immediate
    xlen_t          result;         // alu output
    logic           we;             // wb handshake

    nf_control_unit
    control_unit_0
    (
        .clk        ( clk       ),
        .reset      ( reset     ),
        .in_valid   ( in_valid  ),
        .in_instr   ( in_instr  ),
        .in_ready   ( in_ready  ),
        .rs1        ( rs1       ),
        .rs2        ( rs2       ),
        .instr_q    ( instr_q   ),
        .imm_sel    ( imm_sel   ),
        .srca_sel   ( srca_sel  ),
        .srcb_sel   ( srcb_sel  ),
        .shift_sel  ( shift_sel ),
        .alu_code   ( alu_code  ),
        .result     ( result    ),
        .wb_valid   ( wb_valid  ),
        .wb_ready   ( wb_ready  ),
        .wb_rd      ( wb_rd     ),
        .wb_data    ( wb_data   ),
        .we         ( we        )
    );

    nf_reg_file
    #(
        .REG_COUNT  ( REG_COUNT )
    )
    reg_file_0
    (
        .clk        ( clk       ),
        .ra1        ( rs1       ),
        .rd1        ( rd1       ),
        .ra2        ( rs2       ),
        .rd2        ( rd2       ),
        .wa         ( wb_rd     ),  // written on the wb transfer
        .we         ( we        ),
        .wd         ( wb_data   )
    );

    nf_sign_ext
    sign_ext_0
    (
        .instr      ( instr_q   ),
        .imm_sel    ( imm_sel   ),
        .ext_data   ( ext_data  )
    );

    nf_i_exu
    i_exu_0
    (
        .rd1        ( rd1                   ),
        .rd2        ( rd2                   ),
        .ext_data   ( ext_data              ),
        .srca_sel   ( srca_sel              ),
        .srcb_sel   ( srcb_sel              ),
        .shift_sel  ( shift_sel             ),
        .shamt      ( instr_q[24 : 20]      ),  // i-type shamt field
        .alu_code   ( alu_code              ),
        .result     ( result                )
    );

endmodule : nf_exec_top

// ==== source/nf_control_unit.sv ====
`timescale 1ns/1ps

module nf_control_unit
(
    input   logic                           clk,        // clock
    input   logic                           reset,      // sync reset, active high
    input   logic                           in_valid,   // instruction offered
    input   nf_settings_pkg::instr_t        in_instr,   // instruction word
    output  logic                           in_ready,   // stage can accept
    output  nf_settings_pkg::reg_addr_t     rs1,        // source reg 1 index
    output  nf_settings_pkg::reg_addr_t     rs2,        // source reg 2 index
    output  nf_settings_pkg::instr_t        instr_q,    // held instruction
    output  nf_cpu_pkg::imm_sel_t           imm_sel,    // immediate format
    output  nf_cpu_pkg::srca_sel_t          srca_sel,   // alu a select
    output  nf_cpu_pkg::srcb_sel_t          srcb_sel,   // alu b select
    output  nf_cpu_pkg::shift_sel_t         shift_sel,  // shift amount select
    output  nf_cpu_pkg::alu_code_t          alu_code,   // alu operation
    input   nf_settings_pkg::xlen_t         result,     // alu result from exu
    output  logic                           wb_valid,   // write-back offered
    input   logic                           wb_ready,   // sink takes write-back
    output  nf_settings_pkg::reg_addr_t     wb_rd,      // destination index
    output  nf_settings_pkg::xlen_t         wb_data,    // destination data
    output  logic                           we          // reg file write enable
);

    import nf_settings_pkg::*;
    import nf_cpu_pkg::*;

    ctrl_state_t    state;              // current fsm state
    ctrl_state_t    state_next;         // next fsm state
    logic   [6 : 0] opcode;             // major opcode of held instr
    logic   [2 : 0] funct3;             // operation field
    logic           funct7_b5;          // sub / sra marker
    logic           legal;              // opcode supported
    alu_code_t      alu_f3;             // alu op picked by funct3

    assign opcode    = instr_q[6 : 0];
    assign funct3    = instr_q[14 : 12];
    assign funct7_b5 = instr_q[30];
    assign rs1       = instr_q[19 : 15];
    assign rs2       = instr_q[24 : 20];
    assign wb_rd     = instr_q[11 : 7];    // stable until next accept

    assign in_ready  = (state == ST_IDLE);
    assign wb_valid  = (state == ST_WB);
    assign we        = wb_valid && wb_ready;  // reg write on the wb handshake

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE :   if (in_valid) state_next = ST_EXEC;
            ST_EXEC :   state_next = legal ? ST_WB : ST_IDLE;   // illegal op is dropped
            ST_WB   :   if (wb_ready) state_next = ST_IDLE;
            default :   state_next = ST_IDLE;
        endcase
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
            instr_q <= in_instr;        // capture on accept
        if (state == ST_EXEC)
            wb_data <= result;          // alu output settles in exec
    end

    // funct3 to alu op, sub only for r-type
    always_comb
    begin
        case (funct3)
            F3_ADD_SUB  :   alu_f3 = (opcode == OP_R && funct7_b5) ? ALU_SUB : ALU_ADD;
            F3_SLL      :   alu_f3 = ALU_SLL;
            F3_SLT      :   alu_f3 = ALU_SLT;
            F3_SLTU     :   alu_f3 = ALU_SLTU;
            F3_XOR      :   alu_f3 = ALU_XOR;
            F3_SRL_SRA  :   alu_f3 = funct7_b5 ? ALU_SRA : ALU_SRL;
            F3_OR       :   alu_f3 = ALU_OR;
            F3_AND      :   alu_f3 = ALU_AND;
            default     :   alu_f3 = ALU_ADD;
        endcase
    end

    always_comb
    begin
        legal     = 1'b1;
        imm_sel   = IMM_I;
        srca_sel  = SRCA_RD1;
        srcb_sel  = SRCB_RD2;
        shift_sel = SRCS_SHAMT;
        alu_code  = alu_f3;
        case (opcode)
            OP_R    :   shift_sel = SRCS_RD2;       // shift by rs2 value
            OP_I    :   srcb_sel  = SRCB_IMM;       // shamt from instr
            OP_LUI  :
            begin
                imm_sel   = IMM_U;
                srca_sel  = SRCA_IMM;
                shift_sel = SRCS_12;
                alu_code  = ALU_SLL;                // imm20 << 12
            end
            default :   legal = 1'b0;
        endcase
    end

    // write-back held steady under back-pressure
    assert property (@(posedge clk) disable iff (reset)
        (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb_data)))
        else $error("write-back changed while stalled");

endmodule : nf_control_unit

// ==== source/nf_reg_file.sv ====
`timescale 1ns/1ps

module nf_reg_file
#(
    parameter int REG_COUNT = 32                // 16 gives rv32e
)
(
    input   logic                           clk,    // clock
    input   nf_settings_pkg::reg_addr_t     ra1,    // read address 1
    output  nf_settings_pkg::xlen_t         rd1,    // read data 1
    input   nf_settings_pkg::reg_addr_t     ra2,    // read address 2
    output  nf_settings_pkg::xlen_t         rd2,    // read data 2
    input   nf_settings_pkg::reg_addr_t     wa,     // write address
    input   logic                           we,     // write enable
    input   nf_settings_pkg::xlen_t         wd      // write data
);

    import nf_settings_pkg::*;

    xlen_t  regs [REG_COUNT];       // storage, entry 0 never written

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];     // x0 reads as zero
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

    always_ff @(posedge clk)
    begin
        if (we && wa != '0)
            regs[wa] <= wd;
    end

    // writes must stay inside the implemented file
    assert property (@(posedge clk) we |-> (int'(wa) < REG_COUNT))
        else $error("write to register %0d beyond REG_COUNT", wa);

endmodule : nf_reg_file

// ==== source/nf_sign_ext.sv ====
`timescale 1ns/1ps

module nf_sign_ext
(
    input   nf_settings_pkg::instr_t        instr,      // held instruction
    input   nf_cpu_pkg::imm_sel_t           imm_sel,    // immediate format
    output  nf_settings_pkg::xlen_t         ext_data    // extended immediate
);

    import nf_settings_pkg::*;
    import nf_cpu_pkg::*;

    always_comb
    begin
        ext_data = '0;
        case (imm_sel)
            IMM_I   :   ext_data = { {20{instr[31]}}, instr[31 : 20] };   // 12-bit signed
            // upper field kept low, the alu shifts it by 12 for lui
            IMM_U   :   ext_data = { 12'b0, instr[31 : 12] };
            default :   ;
        endcase
    end

endmodule : nf_sign_ext

// ==== source/nf_i_exu.sv ====
`timescale 1ns/1ps

module nf_i_exu
(
    input   nf_settings_pkg::xlen_t         rd1,        // rs1 value
    input   nf_settings_pkg::xlen_t         rd2,        // rs2 value
    input   nf_settings_pkg::xlen_t         ext_data,   // extended immediate
    input   nf_cpu_pkg::srca_sel_t          srca_sel,   // alu a select
    input   nf_cpu_pkg::srcb_sel_t          srcb_sel,   // alu b select
    input   nf_cpu_pkg::shift_sel_t         shift_sel,  // shift amount select
    input   nf_settings_pkg::shamt_t        shamt,      // instr shamt field
    input   nf_cpu_pkg::alu_code_t          alu_code,   // alu operation
    output  nf_settings_pkg::xlen_t         result      // alu result
);

    import nf_settings_pkg::*;
    import nf_cpu_pkg::*;

    xlen_t  srca;       // alu operand a
    xlen_t  srcb;       // alu operand b
    shamt_t shift;      // alu shift amount

    always_comb
    begin
        srca = rd1;
        case (srca_sel)
            SRCA_IMM    :   srca = ext_data;    // lui path
            SRCA_RD1    :   srca = rd1;
            default     :   ;
        endcase
    end

    always_comb
    begin
        srcb = rd2;
        case (srcb_sel)
            SRCB_RD2    :   srcb = rd2;
            SRCB_IMM    :   srcb = ext_data;
            default     :   ;
        endcase
    end

    always_comb
    begin
        shift = shamt;
        case (shift_sel)
            SRCS_SHAMT  :   shift = shamt;
            SRCS_RD2    :   shift = rd2[4 : 0];     // only low 5 bits count
            SRCS_12     :   shift = 5'd12;
            default     :   ;
        endcase
    end

    nf_alu
    alu_0
    (
        .srca       ( srca      ),
        .srcb       ( srcb      ),
        .shift      ( shift     ),
        .alu_code   ( alu_code  ),
        .result     ( result    )
    );

endmodule : nf_i_exu

// ==== source/nf_alu.sv ====
`timescale 1ns/1ps

module nf_alu
(
    input   nf_settings_pkg::xlen_t         srca,       // operand a, also shift source
    input   nf_settings_pkg::xlen_t         srcb,       // operand b
    input   nf_settings_pkg::shamt_t        shift,      // shift amount
    input   nf_cpu_pkg::alu_code_t          alu_code,   // operation
    output  nf_settings_pkg::xlen_t         result      // result
);

    import nf_settings_pkg::*;
    import nf_cpu_pkg::*;

    logic   lt_s;       // signed less-than
    logic   lt_u;       // unsigned less-than

    assign lt_s = $signed(srca) < $signed(srcb);
    assign lt_u = srca < srcb;

    always_comb
    begin
        result = '0;
        case (alu_code)
            ALU_ADD     :   result = srca + srcb;
            ALU_SUB     :   result = srca - srcb;
            ALU_SLL     :   result = srca << shift;
            ALU_SRL     :   result = srca >> shift;
            ALU_SRA     :   result = xlen_t'($signed(srca) >>> shift);   // sign fill
            ALU_SLT     :   result = { {(XLEN-1){1'b0}}, lt_s };
            ALU_SLTU    :   result = { {(XLEN-1){1'b0}}, lt_u };
            ALU_XOR     :   result = srca ^ srcb;
            ALU_OR      :   result = srca | srcb;
            ALU_AND     :   result = srca & srcb;
            default     :   ;
        endcase
    end

endmodule : nf_alu

// ==== source/nf_cpu_pkg.sv ====
package nf_cpu_pkg;

    // major opcodes handled by the stage
    localparam logic [6 : 0] OP_R       = 7'b0110011;   // register-register alu
    localparam logic [6 : 0] OP_I       = 7'b0010011;   // register-immediate alu
    localparam logic [6 : 0] OP_LUI     = 7'b0110111;   // load upper immediate

    localparam logic [2 : 0] F3_ADD_SUB = 3'b000;       // add, sub, addi
    localparam logic [2 : 0] F3_SLL     = 3'b001;       // sll, slli
    localparam logic [2 : 0] F3_SLT     = 3'b010;       // slt, slti
    localparam logic [2 : 0] F3_SLTU    = 3'b011;       // sltu, sltiu
    localparam logic [2 : 0] F3_XOR     = 3'b100;       // xor, xori
    localparam logic [2 : 0] F3_SRL_SRA = 3'b101;       // srl, sra, srli, srai
    localparam logic [2 : 0] F3_OR      = 3'b110;       // or, ori
    localparam logic [2 : 0] F3_AND     = 3'b111;       // and, andi

    typedef enum logic [3 : 0]
    {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SRL  = 4'd3,
        ALU_SRA  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_code_t;

    typedef enum logic [1 : 0] { SRCA_IMM = 2'd0, SRCA_RD1 = 2'd1 } srca_sel_t;   // alu a mux
    typedef enum logic [0 : 0] { SRCB_RD2 = 1'b0, SRCB_IMM = 1'b1 } srcb_sel_t;   // alu b mux

    typedef enum logic [1 : 0]
    {
        SRCS_SHAMT = 2'd0,          // instruction shamt field
        SRCS_RD2   = 2'd1,          // low bits of rs2 value
        SRCS_12    = 2'd2           // constant, for lui
    } shift_sel_t;

    typedef enum logic [0 : 0] { IMM_I = 1'b0, IMM_U = 1'b1 } imm_sel_t;          // immediate format

    // control fsm of the execute stage
    typedef enum logic [1 : 0] { ST_IDLE = 2'd0, ST_EXEC = 2'd1, ST_WB = 2'd2 } ctrl_state_t;

endpackage : nf_cpu_pkg

// ==== source/nf_settings_pkg.sv ====
package nf_settings_pkg;

    localparam int XLEN = 32;                       // data path width

    typedef logic [XLEN-1 : 0]  xlen_t;             // data word
    typedef logic [31 : 0]      instr_t;            // instruction word, fixed by the isa
    typedef logic [4  : 0]      reg_addr_t;         // register index
    typedef logic [4  : 0]      shamt_t;            // shift amount

endpackage : nf_settings_pkg
